//--- logic/liq_consts.svh
`ifndef LIQ_CONSTS_SVH
`define LIQ_CONSTS_SVH

// bank count doubles as dispatch port and load pipeline count.
`define LIQ_BANK_NUM 2
`define LIQ_BANK_SIZE 8
`define LIQ_IDX_W ($clog2(`LIQ_BANK_SIZE))
`define LIQ_CNT_W (`LIQ_IDX_W + 1)

`define PREG_W 6
`define WB_NUM 2

// rob index width, wrap bit excluded.
`define ROB_W 5
`define LQ_W 4

`endif

//--- logic/liq_pkg.sv
`default_nettype none

`include "liq_consts.svh"

package liq_pkg;

    // wrap bit flips each time the rob pointer laps.
    typedef struct packed {
        logic              dir;
        logic [`ROB_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        rob_idx_t           rob_idx;
        logic [`LQ_W-1:0]   lq_idx;
        logic [`PREG_W-1:0] rd;
        logic [11:0]        imm;
        logic [1:0]         size;  // 0 byte, 1 half, 2 word.
        logic               uext;
    } load_payload_t;

endpackage

`default_nettype wire

//--- logic/dispatch_router.sv
`default_nettype none
`timescale 1ns/1ns

`include "liq_consts.svh"

module dispatch_router (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`LIQ_BANK_NUM-1:0][`LIQ_CNT_W-1:0]    bank_count,
    input  logic [`LIQ_BANK_NUM-1:0]                    bank_full,
    input  logic [`LIQ_BANK_NUM-1:0]                    dis_en,
    input  logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]       dis_rs1,
    input  logic [`LIQ_BANK_NUM-1:0]                    dis_rs1v,
    input  liq_pkg::load_payload_t [`LIQ_BANK_NUM-1:0]  dis_payload,
    output logic                                        dis_full,
    output logic [`LIQ_BANK_NUM-1:0]                    bank_wr_en,
    output logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]       bank_rs1,
    output logic [`LIQ_BANK_NUM-1:0]                    bank_rs1v,
    output liq_pkg::load_payload_t [`LIQ_BANK_NUM-1:0]  bank_payload
);

    localparam int ORD_W = (`LIQ_BANK_NUM > 1) ? $clog2(`LIQ_BANK_NUM) : 1;

    logic [`LIQ_BANK_NUM-1:0][ORD_W-1:0] rank;
    logic [`LIQ_BANK_NUM-1:0][ORD_W-1:0] order;  // port feeding each bank.

    // rank = banks that are emptier, ties broken by index.
    always_comb begin
        for (int i = 0; i < `LIQ_BANK_NUM; i++) begin
            rank[i] = '0;
            for (int k = 0; k < `LIQ_BANK_NUM; k++) begin
                if ((bank_count[k] < bank_count[i]) ||
                    ((bank_count[k] == bank_count[i]) && (k < i))) begin
                    rank[i] = rank[i] + ORD_W'(1);
                end
            end
        end
    end

    // one cycle stale, which keeps the sort off the dispatch path.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LIQ_BANK_NUM; i++) begin
                order[i] <= ORD_W'(i);
            end
        end else begin
            order <= rank;
        end
    end

    assign dis_full = |bank_full;

    always_comb begin
        for (int i = 0; i < `LIQ_BANK_NUM; i++) begin
            bank_wr_en[i]   = dis_en[order[i]] & ~dis_full;
            bank_rs1[i]     = dis_rs1[order[i]];
            bank_rs1v[i]    = dis_rs1v[order[i]];
            bank_payload[i] = dis_payload[order[i]];
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_bank.sv
`default_nettype none
`timescale 1ns/1ns

`include "liq_consts.svh"

module issue_bank (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wr_en,
    input  logic [`PREG_W-1:0]                  wr_rs1,
    input  logic                                wr_rs1v,
    input  liq_pkg::load_payload_t              wr_payload,
    input  logic [`WB_NUM-1:0]                  wb_en,
    input  logic [`WB_NUM-1:0][`PREG_W-1:0]     wb_rd,
    input  logic                                grant,
    input  logic                                reply_en,
    input  logic [`LIQ_IDX_W-1:0]               reply_idx,
    input  logic                                success_en,
    input  logic [`LIQ_IDX_W-1:0]               success_idx,
    input  logic                                redirect,
    input  liq_pkg::rob_idx_t                   redirect_rob_idx,
    output logic                                full,
    output logic [`LIQ_CNT_W-1:0]               count,
    output logic                                req,
    output logic [`PREG_W-1:0]                  pick_rs1,
    output liq_pkg::load_payload_t              pick_payload,
    output logic [`LIQ_IDX_W-1:0]               pick_idx
);

    import liq_pkg::*;

    localparam int SIZE = `LIQ_BANK_SIZE;

    logic [SIZE-1:0]              valid;
    logic [SIZE-1:0]              issued;
    logic [SIZE-1:0]              rs1v;
    logic [SIZE-1:0][`PREG_W-1:0] rs1;
    load_payload_t                payload_q [SIZE];

    logic [SIZE-1:0]              ready;
    logic [SIZE-1:0]              woken;
    logic [SIZE-1:0]              older;
    logic                         wr_woken;
    logic [`LIQ_IDX_W-1:0]        free_idx;
    rob_idx_t                     ent_rob;

    assign ready = valid & rs1v & ~issued;
    assign req   = |ready;
    assign full  = &valid;

    // lowest free slot and lowest ready slot.
    always_comb begin
        free_idx = '0;
        pick_idx = '0;
        for (int i = SIZE - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = `LIQ_IDX_W'(i);
            end
            if (ready[i]) begin
                pick_idx = `LIQ_IDX_W'(i);
            end
        end
    end

    always_comb begin
        count = '0;
        for (int i = 0; i < SIZE; i++) begin
            count = count + `LIQ_CNT_W'(valid[i]);
        end
    end

    assign pick_rs1     = rs1[pick_idx];
    assign pick_payload = payload_q[pick_idx];

    // tag match against the writeback ports, incoming load included.
    always_comb begin
        wr_woken = 1'b0;
        for (int i = 0; i < SIZE; i++) begin
            woken[i] = 1'b0;
            for (int j = 0; j < `WB_NUM; j++) begin
                woken[i] = woken[i] | (wb_en[j] & (wb_rd[j] == rs1[i]));
            end
        end
        for (int j = 0; j < `WB_NUM; j++) begin
            wr_woken = wr_woken | (wb_en[j] & (wb_rd[j] == wr_rs1));
        end
    end

    // wrap bits differ -> the ordering of idx flips.
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            ent_rob  = payload_q[i].rob_idx;
            older[i] = (ent_rob.dir ^ redirect_rob_idx.dir) ?
                       (ent_rob.idx > redirect_rob_idx.idx) :
                       (ent_rob.idx < redirect_rob_idx.idx);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid  <= '0;
            issued <= '0;
            rs1v   <= '0;
        end else begin
            rs1v <= rs1v | woken;
            if (redirect) begin
                valid <= valid & older;  // younger ones are squashed.
            end else begin
                if (grant) begin
                    issued[pick_idx] <= 1'b1;
                end
                if (reply_en) begin
                    issued[reply_idx] <= 1'b0;  // back in the race.
                end
                if (success_en) begin
                    valid[success_idx] <= 1'b0;
                end
                if (wr_en) begin
                    valid[free_idx]  <= 1'b1;
                    issued[free_idx] <= 1'b0;
                    rs1v[free_idx]   <= wr_rs1v | wr_woken;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            rs1[free_idx]       <= wr_rs1;
            payload_q[free_idx] <= wr_payload;
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_collector.sv
`default_nettype none
`timescale 1ns/1ns

`include "liq_consts.svh"

module issue_collector (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`LIQ_BANK_NUM-1:0]                    req,
    input  liq_pkg::load_payload_t [`LIQ_BANK_NUM-1:0]  pick_payload,
    input  logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]    pick_idx,
    input  logic [`LIQ_BANK_NUM-1:0]                    rf_ready,
    input  logic                                        redirect,
    output logic [`LIQ_BANK_NUM-1:0]                    rf_req,
    output logic [`LIQ_BANK_NUM-1:0]                    grant,
    output logic [`LIQ_BANK_NUM-1:0]                    issue_en,
    output liq_pkg::load_payload_t [`LIQ_BANK_NUM-1:0]  issue_payload,
    output logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]    issue_idx
);

    // nothing goes to the register file while the back end redirects.
    assign rf_req = req & {`LIQ_BANK_NUM{~redirect}};
    assign grant  = rf_req & rf_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_en <= '0;
        end else begin
            issue_en <= grant;
        end
    end

    // payload only moves on a grant.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LIQ_BANK_NUM; i++) begin
            if (grant[i]) begin
                issue_payload[i] <= pick_payload[i];
                issue_idx[i]     <= pick_idx[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/load_issue_queue.sv
`default_nettype none
`timescale 1ns/1ns

`include "liq_consts.svh"

module load_issue_queue (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`LIQ_BANK_NUM-1:0]                    dis_en,
    input  logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]       dis_rs1,
    input  logic [`LIQ_BANK_NUM-1:0]                    dis_rs1v,
    input  liq_pkg::load_payload_t [`LIQ_BANK_NUM-1:0]  dis_payload,
    output logic                                        dis_full,
    input  logic [`WB_NUM-1:0]                          wb_en,
    input  logic [`WB_NUM-1:0][`PREG_W-1:0]             wb_rd,
    output logic [`LIQ_BANK_NUM-1:0]                    rf_req,
    output logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]       rf_rs1,
    input  logic [`LIQ_BANK_NUM-1:0]                    rf_ready,
    output logic [`LIQ_BANK_NUM-1:0]                    issue_en,
    output liq_pkg::load_payload_t [`LIQ_BANK_NUM-1:0]  issue_payload,
    output logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]    issue_idx,
    input  logic [`LIQ_BANK_NUM-1:0]                    reply_en,
    input  logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]    reply_idx,
    input  logic [`LIQ_BANK_NUM-1:0]                    success_en,
    input  logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]    success_idx,
    input  logic                                        redirect,
    input  liq_pkg::rob_idx_t                           redirect_rob_idx
);

    import liq_pkg::*;

    logic [`LIQ_BANK_NUM-1:0][`LIQ_CNT_W-1:0]   bank_count;
    logic [`LIQ_BANK_NUM-1:0]                   bank_full;
    logic [`LIQ_BANK_NUM-1:0]                   bank_wr_en;
    logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]      bank_rs1;
    logic [`LIQ_BANK_NUM-1:0]                   bank_rs1v;
    load_payload_t [`LIQ_BANK_NUM-1:0]          bank_payload;
    logic [`LIQ_BANK_NUM-1:0]                   bank_req;
    load_payload_t [`LIQ_BANK_NUM-1:0]          pick_payload;
    logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]   pick_idx;
    logic [`LIQ_BANK_NUM-1:0]                   grant;

    dispatch_router router_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bank_count   (bank_count),
        .bank_full    (bank_full),
        .dis_en       (dis_en),
        .dis_rs1      (dis_rs1),
        .dis_rs1v     (dis_rs1v),
        .dis_payload  (dis_payload),
        .dis_full     (dis_full),
        .bank_wr_en   (bank_wr_en),
        .bank_rs1     (bank_rs1),
        .bank_rs1v    (bank_rs1v),
        .bank_payload (bank_payload)
    );

    // bank i feeds load pipeline i.
    for (genvar i = 0; i < `LIQ_BANK_NUM; i++) begin : g_bank
        issue_bank bank_i (
            .clk              (clk),
            .rst_n            (rst_n),
            .wr_en            (bank_wr_en[i]),
            .wr_rs1           (bank_rs1[i]),
            .wr_rs1v          (bank_rs1v[i]),
            .wr_payload       (bank_payload[i]),
            .wb_en            (wb_en),
            .wb_rd            (wb_rd),
            .grant            (grant[i]),
            .reply_en         (reply_en[i]),
            .reply_idx        (reply_idx[i]),
            .success_en       (success_en[i]),
            .success_idx      (success_idx[i]),
            .redirect         (redirect),
            .redirect_rob_idx (redirect_rob_idx),
            .full             (bank_full[i]),
            .count            (bank_count[i]),
            .req              (bank_req[i]),
            .pick_rs1         (rf_rs1[i]),
            .pick_payload     (pick_payload[i]),
            .pick_idx         (pick_idx[i])
        );
    end

    issue_collector collector_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (bank_req),
        .pick_payload  (pick_payload),
        .pick_idx      (pick_idx),
        .rf_ready      (rf_ready),
        .redirect      (redirect),
        .rf_req        (rf_req),
        .grant         (grant),
        .issue_en      (issue_en),
        .issue_payload (issue_payload),
        .issue_idx     (issue_idx)
    );

endmodule

`default_nettype wire

//--- tb/liq_tb_tasks.svh
`ifndef LIQ_TB_TASKS_SVH
`define LIQ_TB_TASKS_SVH

localparam int MODEL_MAX = 64;

// reference model, one slot per accepted load.
load_payload_t         m_payload [MODEL_MAX];
logic [`PREG_W-1:0]    m_rs1 [MODEL_MAX];
logic [MODEL_MAX-1:0]  m_rdy;
logic [MODEL_MAX-1:0]  m_live;
logic [MODEL_MAX-1:0]  m_busy;  // issued, no reply or success yet.
int                    m_issues [MODEL_MAX];
int                    m_pipe [MODEL_MAX];
logic [`LIQ_IDX_W-1:0] m_idx [MODEL_MAX];
int                    m_n = 0;

function automatic load_payload_t rand_payload(input rob_idx_t rob);
    load_payload_t p;
    p.rob_idx = rob;
    p.lq_idx  = `LQ_W'($urandom);
    p.rd      = `PREG_W'($urandom);
    p.imm     = 12'($urandom);
    p.size    = 2'($urandom_range(2, 0));
    p.uext    = 1'($urandom);
    return p;
endfunction

// differing wrap bits reverse the idx order.
function automatic bit older_than(input rob_idx_t a, input rob_idx_t r);
    return (a.dir != r.dir) ? (a.idx > r.idx) : (a.idx < r.idx);
endfunction

function automatic int find_load(input load_payload_t p);
    for (int k = 0; k < m_n; k++) begin
        if (m_live[k] && m_payload[k] == p) begin
            return k;
        end
    end
    return -1;
endfunction

function automatic int pending();
    int n = 0;
    for (int k = 0; k < m_n; k++) begin
        n += int'(m_live[k] && m_rdy[k] && !m_busy[k]);
    end
    return n;
endfunction

// one cycle, then every issue is matched against the model.
task automatic step();
    int k;
    @(negedge clk);
    for (int i = 0; i < `LIQ_BANK_NUM; i++) begin
        if (issue_en[i] === 1'b1) begin
            k = find_load(issue_payload[i]);
            issue_known: assert (k >= 0 && m_rdy[k] && !m_busy[k]) else begin
                errors++;
                $display("%s: pipe %0d issued a load that was not waiting to issue",
                         test_name, i);
            end
            if (k >= 0) begin
                issue_rs1: assert (granted_rs1[i] == m_rs1[k]) else begin
                    errors++;
                    $display("** Error %s: expected rf_rs1 %0d, actual %0d",
                             test_name, m_rs1[k], granted_rs1[i]);
                end
                m_issues[k]++;
                m_busy[k] = 1'b1;
                m_pipe[k] = i;
                m_idx[k]  = issue_idx[i];
            end
        end
    end
endtask

task automatic dispatch(input logic [`LIQ_BANK_NUM-1:0] en, input logic [`PREG_W-1:0] tag,
                        input logic rdy, input rob_idx_t rob, input bit keep = 1'b1);
    accept_state: assert (dis_full === !keep) else begin
        errors++;
        $display("** Error %s: expected dis_full %b, actual %b", test_name, !keep, dis_full);
    end
    for (int i = 0; i < `LIQ_BANK_NUM; i++) begin
        dis_payload[i] = rand_payload(rob);
        dis_rs1[i]     = tag;
        if (en[i] && keep) begin
            m_payload[m_n] = dis_payload[i];
            m_rs1[m_n]     = tag;
            m_rdy[m_n]     = rdy;
            m_live[m_n]    = 1'b1;
            m_busy[m_n]    = 1'b0;
            m_issues[m_n]  = 0;
            m_n++;
        end
    end
    dis_rs1v = {`LIQ_BANK_NUM{rdy}};
    dis_en   = en;
    step();
    dis_en = '0;
endtask

task automatic wake(input logic [`PREG_W-1:0] t0, input logic [`PREG_W-1:0] t1);
    wb_en = '1;
    for (int j = 0; j < `WB_NUM; j++) begin
        wb_rd[j] = j[0] ? t1 : t0;
    end
    for (int k = 0; k < m_n; k++) begin
        m_rdy[k] = m_rdy[k] | (m_rs1[k] == t0) | (m_rs1[k] == t1);
    end
    step();
    wb_en = '0;
endtask

// reply puts the load back in the race, success retires it.
task automatic respond(input int k, input bit replay);
    reply_en[m_pipe[k]]    = replay;
    success_en[m_pipe[k]]  = !replay;
    reply_idx[m_pipe[k]]   = m_idx[k];
    success_idx[m_pipe[k]] = m_idx[k];
    m_busy[k] = 1'b0;
    m_live[k] = replay;
    step();
    reply_en   = '0;
    success_en = '0;
endtask

task automatic flush(input rob_idx_t r);
    redirect         = 1'b1;
    redirect_rob_idx = r;
    for (int k = 0; k < m_n; k++) begin
        if (m_live[k] && !older_than(m_payload[k].rob_idx, r)) begin
            m_live[k] = 1'b0;
        end
    end
    step();
    redirect = 1'b0;
endtask

task automatic wait_idle();
    int n = 0;
    while (pending() != 0 && n < 100) begin
        step();
        n++;
    end
    drained: assert (pending() == 0) else begin
        errors++;
        $display("%s: loads still waiting to issue after %0d cycles", test_name, n);
    end
    repeat (3) step();  // room for a stray issue.
endtask

task automatic close_test(input int n);
    wait_idle();
    for (int k = test_first; k < m_n; k++) begin
        issue_count: assert (m_issues[k] == (m_live[k] ? n : 0)) else begin
            errors++;
            $display("** Error %s: load %0d expected %0d issues, actual %0d",
                     test_name, k, m_live[k] ? n : 0, m_issues[k]);
        end
    end
    for (int k = 0; k < m_n; k++) begin
        if (m_live[k] && m_busy[k]) begin
            respond(k, 1'b0);
        end
    end
    repeat (3) step();
    end_test();
endtask

`endif

//--- tb/load_issue_queue_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "liq_consts.svh"

module load_issue_queue_tb;

    import liq_pkg::*;

    // about 36 driver operations, 40 cycles each, plus margin.
    localparam int CYCLE_LIMIT = 36 * 40 + 200;
    localparam logic [5:0] ROB_SET [6] = '{6'h03, 6'h09, 6'h0a, 6'h0c, 6'h22, 6'h34};

    logic                                       clk;
    logic                                       rst_n;
    logic [`LIQ_BANK_NUM-1:0]                   dis_en;
    logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]      dis_rs1;
    logic [`LIQ_BANK_NUM-1:0]                   dis_rs1v;
    load_payload_t [`LIQ_BANK_NUM-1:0]          dis_payload;
    logic                                       dis_full;
    logic [`WB_NUM-1:0]                         wb_en;
    logic [`WB_NUM-1:0][`PREG_W-1:0]            wb_rd;
    logic [`LIQ_BANK_NUM-1:0]                   rf_req;
    logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]      rf_rs1;
    logic [`LIQ_BANK_NUM-1:0]                   rf_ready;
    logic [`LIQ_BANK_NUM-1:0]                   issue_en;
    load_payload_t [`LIQ_BANK_NUM-1:0]          issue_payload;
    logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]   issue_idx;
    logic [`LIQ_BANK_NUM-1:0]                   reply_en;
    logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]   reply_idx;
    logic [`LIQ_BANK_NUM-1:0]                   success_en;
    logic [`LIQ_BANK_NUM-1:0][`LIQ_IDX_W-1:0]   success_idx;
    logic                                       redirect;
    rob_idx_t                                   redirect_rob_idx;

    logic [`LIQ_BANK_NUM-1:0]                   granted;
    logic [`LIQ_BANK_NUM-1:0][`PREG_W-1:0]      granted_rs1;

    int    errors     = 0;
    int    passed     = 0;
    int    failed     = 0;
    int    test_err0  = 0;
    int    test_first = 0;
    int    cycles     = 0;
    string test_name  = "reset";

    load_issue_queue dut_i (.*);

    `include "liq_tb_tasks.svh"

    task automatic begin_test(input string name);
        test_name  = name;
        test_err0  = errors;
        test_first = m_n;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            passed++;
            $display("test %-8s done, no errors", test_name);
        end else begin
            failed++;
            $display("test %-8s done, %0d errors", test_name, errors - test_err0);
        end
    endtask

    // grant and register tag seen at each edge.
    always @(posedge clk) begin
        granted     <= rf_req & rf_ready;
        granted_rs1 <= rf_rs1;
    end

    issue_follows_grant: assert property (@(posedge clk) disable iff (!rst_n)
        issue_en == granted)
    else begin
        errors++;
        $display("** Error %s: expected issue_en %b, actual %b", test_name,
                 $sampled(granted), $sampled(issue_en));
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, a test never finished", cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(46511));
        rst_n            = 1'b0;
        dis_en           = '0;
        dis_rs1          = '0;
        dis_rs1v         = '0;
        dis_payload      = '0;
        wb_en            = '0;
        wb_rd            = '0;
        rf_ready         = '1;
        reply_en         = '0;
        reply_idx        = '0;
        success_en       = '0;
        success_idx      = '0;
        redirect         = 1'b0;
        redirect_rob_idx = '0;
        m_rdy            = '0;
        m_live           = '0;
        m_busy           = '0;

        begin_test("reset");
        for (int c = 0; c < 7; c++) begin
            step();
            quiet: assert (issue_en == '0 && rf_req == '0 && !dis_full) else begin
                errors++;
                $display("** Error %s: expected issue_en/rf_req/dis_full 0/0/0, actual %b/%b/%b",
                         test_name, issue_en, rf_req, dis_full);
            end
            rst_n = (c >= 4);
        end
        end_test();

        begin_test("direct");
        dispatch(`LIQ_BANK_NUM'(1), 6'd1, 1'b1, '0);
        not_yet: assert (issue_en == '0) else begin
            errors++;
            $display("** Error %s: expected issue_en 0, actual %b", test_name, issue_en);
        end
        step();
        on_time: assert (issue_en[0] && issue_payload[0] == m_payload[m_n - 1]) else begin
            errors++;
            $display("** Error %s: expected pipe 0 load %h, actual %b %h", test_name,
                     m_payload[m_n - 1], issue_en, issue_payload[0]);
        end
        close_test(1);

        begin_test("wakeup");
        for (int t = 0; t < 3; t++) begin
            dispatch(`LIQ_BANK_NUM'(1), `PREG_W'(10 + t), 1'b0, '0);
        end
        repeat (4) step();
        wake(6'd10, 6'd11);
        wake(6'd12, 6'd12);
        close_test(1);

        begin_test("replay");
        rf_ready = '0;
        dispatch(`LIQ_BANK_NUM'(1), 6'd20, 1'b1, '0);
        for (int c = 0; c < 3; c++) begin
            step();
            held: assert (rf_req != '0 && issue_en == '0) else begin
                errors++;
                $display("** Error %s: expected rf_req set and issue_en 0, actual %b and %b",
                         test_name, rf_req, issue_en);
            end
        end
        rf_ready = '1;
        wait_idle();
        respond(m_n - 1, 1'b1);
        close_test(2);

        begin_test("full");
        for (int c = 0; c < `LIQ_BANK_SIZE; c++) begin
            dispatch('1, `PREG_W'(40 + c % 4), 1'b0, '0);
        end
        dispatch('1, 6'd40, 1'b0, '0, 1'b0);  // offered while full.
        dispatch('1, 6'd41, 1'b0, '0, 1'b0);
        wake(6'd40, 6'd41);
        wake(6'd42, 6'd43);
        close_test(1);

        begin_test("redirect");
        for (int t = 0; t < 6; t++) begin
            dispatch(`LIQ_BANK_NUM'(1), 6'd50, 1'b0, rob_idx_t'(ROB_SET[t]));
        end
        flush(rob_idx_t'(6'h0a));
        wake(6'd50, 6'd50);
        close_test(1);

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
+incdir+tb
logic/liq_pkg.sv
logic/dispatch_router.sv
logic/issue_bank.sv
logic/issue_collector.sv
logic/load_issue_queue.sv
tb/load_issue_queue_tb.sv

//--- Bender.yml
package:
  name: load_issue_queue

sources:
  - include_dirs:
      - logic
    files:
      - logic/liq_pkg.sv
      - logic/dispatch_router.sv
      - logic/issue_bank.sv
      - logic/issue_collector.sv
      - logic/load_issue_queue.sv
  - target: test
    include_dirs:
      - logic
      - tb
    files:
      - tb/load_issue_queue_tb.sv
